//--- common/clint_macros.svh
`ifndef CLINT_MACROS_SVH
`define CLINT_MACROS_SVH

// Number of hart slices. The hart field is 4 bits wide, so 1 to 16 are legal.
`define CLINT_NUM_HARTS 4

// Device code in the address that selects the CLINT.
`define CLINT_DEV_ID 4'h1

// Real-time tick period in core clock cycles, must fit in 5 bits.
`define CLINT_RTC_DIV 10

// Register offsets within a hart's window.
`define CLINT_MSIP_OFS     16'h0000
`define CLINT_MTIMECMP_OFS 16'h4000
`define CLINT_MTIME_OFS    16'hbff8
`define CLINT_MEIP_OFS     16'hb000 // Stand-in for a platform interrupt controller.

`endif

//--- common/clint_pkg.sv
package clint_pkg;

  // Message type.
  // Only plain reads and writes reach the CLINT.
  typedef enum logic [1:0] {
    e_op_read  = 2'b00,
    e_op_write = 2'b01
  } clint_op_e;

  // Decoded view of a physical address.
  typedef struct packed {
    logic [7:0]  upper; // Ignored by the decoder.
    logic [3:0]  dev;
    logic [3:0]  hart;
    logic [15:0] offset;
  } clint_addr_fields_s;

  // Same 32 bits seen either as a raw address or as fields.
  typedef union packed {
    logic [31:0]        raw;
    clint_addr_fields_s fields;
  } clint_addr_u;

  // Used for both command and response.
  typedef struct packed {
    clint_op_e   op;
    clint_addr_u addr;
    logic [63:0] data;
  } clint_msg_s;

  // Register selector inside a slice.
  typedef enum logic [1:0] {
    e_reg_msip     = 2'd0,
    e_reg_mtimecmp = 2'd1,
    e_reg_mtime    = 2'd2,
    e_reg_meip     = 2'd3
  } clint_reg_e;

endpackage

//--- logic/rtc_strobe.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module rtc_strobe (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic tick_o
);

  localparam logic [4:0] reload_val = 5'(`CLINT_RTC_DIV - 1);

  logic [4:0] cnt_r;

  // Counts down and reloads on wrap.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_r <= reload_val;
    end else if (cnt_r == 5'd0) begin
      cnt_r <= reload_val;
    end else begin
      cnt_r <= cnt_r - 5'd1;
    end
  end

  assign tick_o = (cnt_r == 5'd0); // One cycle per period.

endmodule

//--- logic/clint_cmd_router.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module clint_cmd_router (
  input  clint_pkg::clint_msg_s                   cmd_i,
  input  logic                                    cmd_valid_i,
  output logic                                    cmd_ready_o,

  input  logic                                    resp_ready_i,
  output clint_pkg::clint_msg_s                   resp_o,
  output logic                                    resp_valid_o,

  output logic [`CLINT_NUM_HARTS-1:0]             slice_valid_o,
  input  logic [`CLINT_NUM_HARTS-1:0][63:0]       slice_rdata_i,
  input  logic [`CLINT_NUM_HARTS-1:0]             slice_hit_i
);

  clint_pkg::clint_addr_fields_s addr_f;
  logic                          xfer;
  logic                          dev_match;
  logic                          hart_ok;
  logic                          sel_hit;
  logic [63:0]                   sel_rdata;

  // No response buffer, so a command goes only when its response can go too.
  assign cmd_ready_o  = resp_ready_i;
  assign resp_valid_o = cmd_valid_i & resp_ready_i;
  assign xfer         = cmd_valid_i & resp_ready_i;

  assign addr_f    = cmd_i.addr.fields;
  assign dev_match = (addr_f.dev == `CLINT_DEV_ID);
  assign hart_ok   = ({1'b0, addr_f.hart} < 5'(`CLINT_NUM_HARTS));

  // Steer valid to the addressed slice and pick up its read data.
  always_comb begin
    slice_valid_o = '0;
    sel_hit       = 1'b0;
    sel_rdata     = '0;
    for (int h = 0; h < `CLINT_NUM_HARTS; h++) begin
      if (addr_f.hart == 4'(h)) begin
        slice_valid_o[h] = xfer & dev_match & hart_ok;
        sel_hit          = slice_hit_i[h];
        sel_rdata        = slice_rdata_i[h];
      end
    end
  end

  // Echo op and addr.
  // Unmapped accesses read as zero.
  always_comb begin
    resp_o.op   = cmd_i.op;
    resp_o.addr = cmd_i.addr;
    if (dev_match && hart_ok && sel_hit) begin
      resp_o.data = sel_rdata; // Old value on a write.
    end else begin
      resp_o.data = '0;
    end
  end

endmodule

//--- clint/clint_slice.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module clint_slice (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  tick_i,

  input  clint_pkg::clint_msg_s cmd_i,
  input  logic                  cmd_valid_i,

  output logic [63:0]           rdata_o,
  output logic                  hit_o,

  output logic                  software_irq_o,
  output logic                  timer_irq_o,
  output logic                  external_irq_o
);

  clint_pkg::clint_reg_e reg_sel;
  logic                  wr_en;
  logic                  mtime_we;
  logic                  mtimecmp_we;
  logic                  msip_we;
  logic                  meip_we;

  logic [63:0]           mtime_r;
  logic [63:0]           mtimecmp_r;
  logic                  msip_r;
  logic                  meip_r;

  // Offset decode.
  always_comb begin
    reg_sel = clint_pkg::e_reg_msip;
    hit_o   = 1'b1;
    case (cmd_i.addr.fields.offset)
      `CLINT_MSIP_OFS:     reg_sel = clint_pkg::e_reg_msip;
      `CLINT_MTIMECMP_OFS: reg_sel = clint_pkg::e_reg_mtimecmp;
      `CLINT_MTIME_OFS:    reg_sel = clint_pkg::e_reg_mtime;
      `CLINT_MEIP_OFS:     reg_sel = clint_pkg::e_reg_meip;
      default:             hit_o   = 1'b0;
    endcase
  end

  // Valid from the router already includes the handshake.
  assign wr_en = cmd_valid_i & hit_o & (cmd_i.op == clint_pkg::e_op_write);

  assign mtime_we    = wr_en & (reg_sel == clint_pkg::e_reg_mtime);
  assign mtimecmp_we = wr_en & (reg_sel == clint_pkg::e_reg_mtimecmp);
  assign msip_we     = wr_en & (reg_sel == clint_pkg::e_reg_msip);
  assign meip_we     = wr_en & (reg_sel == clint_pkg::e_reg_meip);

  // A write beats the tick in the same cycle.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_r <= '0;
    end else if (mtime_we) begin
      mtime_r <= cmd_i.data;
    end else if (tick_i) begin
      mtime_r <= mtime_r + 64'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtimecmp_r <= '1; // Timer interrupt off.
    end else if (mtimecmp_we) begin
      mtimecmp_r <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      msip_r <= 1'b0;
    end else if (msip_we) begin
      msip_r <= cmd_i.data[0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meip_r <= 1'b0;
    end else if (meip_we) begin
      meip_r <= cmd_i.data[0];
    end
  end

  // Current value of the addressed register.
  always_comb begin
    rdata_o = '0;
    if (hit_o) begin
      case (reg_sel)
        clint_pkg::e_reg_msip:     rdata_o = {63'd0, msip_r};
        clint_pkg::e_reg_mtimecmp: rdata_o = mtimecmp_r;
        clint_pkg::e_reg_mtime:    rdata_o = mtime_r;
        clint_pkg::e_reg_meip:     rdata_o = {63'd0, meip_r};
        default:                   rdata_o = '0;
      endcase
    end
  end

  assign software_irq_o = msip_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign external_irq_o = meip_r;

endmodule

//--- clint/clint_top.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module clint_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  clint_pkg::clint_msg_s       cmd_i,
  input  logic                        cmd_valid_i,
  output logic                        cmd_ready_o,

  output clint_pkg::clint_msg_s       resp_o,
  output logic                        resp_valid_o,
  input  logic                        resp_ready_i,

  output logic [`CLINT_NUM_HARTS-1:0] software_irq_o,
  output logic [`CLINT_NUM_HARTS-1:0] timer_irq_o,
  output logic [`CLINT_NUM_HARTS-1:0] external_irq_o
);

  logic                              tick;
  logic [`CLINT_NUM_HARTS-1:0]       slice_valid;
  logic [`CLINT_NUM_HARTS-1:0][63:0] slice_rdata;
  logic [`CLINT_NUM_HARTS-1:0]       slice_hit;

  rtc_strobe strobe ( // Shared by all harts.
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tick_o  (tick)
  );

  clint_cmd_router router (
    .cmd_i         (cmd_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .resp_ready_i  (resp_ready_i),
    .resp_o        (resp_o),
    .resp_valid_o  (resp_valid_o),
    .slice_valid_o (slice_valid),
    .slice_rdata_i (slice_rdata),
    .slice_hit_i   (slice_hit)
  );

  for (genvar h = 0; h < `CLINT_NUM_HARTS; h++) begin : gen_slice
    clint_slice slice (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .tick_i         (tick),
      .cmd_i          (cmd_i),
      .cmd_valid_i    (slice_valid[h]),
      .rdata_o        (slice_rdata[h]),
      .hit_o          (slice_hit[h]),
      .software_irq_o (software_irq_o[h]),
      .timer_irq_o    (timer_irq_o[h]),
      .external_irq_o (external_irq_o[h])
    );
  end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o; // 20 ns period.
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1; // Released just after an edge.
  end

endmodule

//--- tests/tb_clint.sv
`timescale 1ns/100ps
`include "clint_macros.svh"

module tb_clint;

  typedef struct packed {
    logic [7:0]  op;
    logic [7:0]  unit; // Dev code in the upper nibble, hart in the lower.
    logic [15:0] offset;
    logic [63:0] data;
    logic [63:0] expected;
    logic [63:0] mask;
  } trace_entry_s;

  logic                        clk;
  logic                        rst_n;
  clint_pkg::clint_msg_s       cmd;
  logic                        cmd_valid;
  logic                        cmd_ready;
  clint_pkg::clint_msg_s       resp;
  logic                        resp_valid;
  logic                        resp_ready;
  logic [`CLINT_NUM_HARTS-1:0] software_irq;
  logic [`CLINT_NUM_HARTS-1:0] timer_irq;
  logic [`CLINT_NUM_HARTS-1:0] external_irq;

  trace_entry_s trace_q[$];
  logic [31:0]  lfsr;
  int           watchdog_cycles;
  bit           trace_loaded;
  int           test_errors;
  int           pass_count;
  int           fail_count;

  tb_clock_gen clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  clint_top uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .cmd_i          (cmd),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .resp_o         (resp),
    .resp_valid_o   (resp_valid),
    .resp_ready_i   (resp_ready),
    .software_irq_o (software_irq),
    .timer_irq_o    (timer_irq),
    .external_irq_o (external_irq)
  );

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // Ready drops when two drawn bits are both set.
  task automatic pick_ready(output logic rdy);
    logic b0;
    logic b1;
    lfsr = lfsr_next(lfsr);
    b0   = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b1   = lfsr[0];
    rdy  = !(b0 && b1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  function automatic string reg_name(input logic [15:0] ofs);
    clint_pkg::clint_reg_e r;
    string                 s;
    s = "";
    r = clint_pkg::e_reg_msip;
    case (ofs)
      `CLINT_MSIP_OFS:     r = clint_pkg::e_reg_msip;
      `CLINT_MTIMECMP_OFS: r = clint_pkg::e_reg_mtimecmp;
      `CLINT_MTIME_OFS:    r = clint_pkg::e_reg_mtime;
      `CLINT_MEIP_OFS:     r = clint_pkg::e_reg_meip;
      default:             s = "unmapped";
    endcase
    if (s == "") begin
      s = r.name();
    end
    return s;
  endfunction

  task automatic load_trace(output bit ok);
    int           fd;
    int           n;
    int           bad;
    int           delay_total;
    string        line;
    trace_entry_s e;
    logic [7:0]   op_c;
    logic [7:0]   unit;
    logic [15:0]  ofs;
    logic [63:0]  data;
    logic [63:0]  expv;
    logic [63:0]  mask;
    ok          = 1'b0;
    bad         = 0;
    delay_total = 0;
    fd = $fopen("tests/clint_trace.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %h", op_c, unit, ofs, data, expv, mask);
          if (n == 6) begin
            e = '{op: op_c, unit: unit, offset: ofs, data: data, expected: expv, mask: mask};
            trace_q.push_back(e);
            if (op_c == "D") begin
              delay_total += int'(data);
            end
          end else begin
            bad++;
          end
        end
      end
      $fclose(fd);
      watchdog_cycles = trace_q.size() * 200 + delay_total;
      ok = (bad == 0) && (trace_q.size() > 0);
    end
  endtask

  // Holds the command until its response is seen and may throttle ready at random.
  task automatic send_command(input clint_pkg::clint_op_e op, input logic [31:0] addr,
                              input logic [63:0] data, input bit throttle,
                              output clint_pkg::clint_msg_s r);
    bit   done;
    logic rdy;
    done         = 1'b0;
    r            = '0;
    cmd.op       = op;
    cmd.addr.raw = addr;
    cmd.data     = data;
    cmd_valid    = 1'b1;
    while (!done) begin
      rdy = 1'b1;
      if (throttle) begin
        pick_ready(rdy);
      end
      resp_ready = rdy;
      @(negedge clk); // Outputs are settled at mid-cycle.
      check_value("cmd_ready_o", 64'(cmd_ready), 64'(resp_ready));
      check_value("resp_valid_o", 64'(resp_valid), 64'(resp_ready));
      if (resp_valid) begin
        r    = resp;
        done = 1'b1;
      end
      @(posedge clk);
      #2;
    end
    cmd_valid  = 1'b0;
    resp_ready = 1'b1;
    check_value("resp_o.op", 64'(r.op), 64'(op));
    check_value("resp_o.addr", 64'(r.addr.raw), 64'(addr));
  endtask

  task automatic run_entry(input int idx, input trace_entry_s e);
    clint_pkg::clint_msg_s r;
    logic [31:0]           addr;
    logic [63:0]           irq_vec;
    string                 label;
    test_errors = 0;
    addr        = {8'h00, e.unit, e.offset};
    label       = reg_name(e.offset);
    case (e.op)
      "W": begin
        send_command(clint_pkg::e_op_write, addr, e.data, 1'b1, r);
        check_value("resp_o.data", r.data & e.mask, e.expected & e.mask); // Old value.
      end
      "R": begin
        send_command(clint_pkg::e_op_read, addr, 64'd0, 1'b1, r);
        check_value("resp_o.data", r.data & e.mask, e.expected & e.mask);
      end
      "T": begin
        // Ready stays high so the tick window is fixed.
        send_command(clint_pkg::e_op_read, addr, 64'd0, 1'b0, r);
        if (r.data < e.data || r.data > e.expected) begin
          $display("ERR resp_o.data: mtime 0x%h outside 0x%h to 0x%h", r.data, e.data,
                   e.expected);
          test_errors++;
        end
      end
      "I": begin
        label = "irq";
        @(negedge clk);
        irq_vec = 64'({external_irq, timer_irq, software_irq});
        check_value("{external_irq_o, timer_irq_o, software_irq_o}", irq_vec & e.mask,
                    e.expected & e.mask);
        @(posedge clk);
        #2;
      end
      "D": begin
        label = "delay";
        repeat (int'(e.data)) begin
          @(negedge clk);
          check_value("resp_valid_o", 64'(resp_valid), 64'd0); // Nothing pending.
          @(posedge clk);
        end
        #2;
      end
      default: begin
        $display("Unknown operation letter %c in trace entry %0d", e.op, idx);
        test_errors++;
      end
    endcase
    if (test_errors == 0) begin
      pass_count++;
      $display("test %0d %c unit %h %s ok", idx, e.op, e.unit, label);
    end else begin
      fail_count++;
      $display("test %0d %c unit %h %s FAILED", idx, e.op, e.unit, label);
    end
  endtask

  initial begin
    bit ok;
    cmd             = '0;
    cmd_valid       = 1'b0;
    resp_ready      = 1'b1;
    lfsr            = 32'h6f06b6c6;
    trace_loaded    = 1'b0;
    watchdog_cycles = 0;
    test_errors     = 0;
    pass_count      = 0;
    fail_count      = 0;
    load_trace(ok);
    if (!ok) begin
      $display("Trace file tests/clint_trace.txt is missing or has a malformed line");
      fail_count++;
    end else begin
      trace_loaded = 1'b1;
      wait (rst_n === 1'b1);
      @(posedge clk);
      #2;
      foreach (trace_q[i]) begin
        run_entry(i, trace_q[i]);
      end
    end
    $display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    wait (trace_loaded);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- tests/clint_trace.txt
# Columns (hex): op unit offset data expected mask, unit = {dev, hart}.
# W/R: response data vs expected under mask. T: data <= mtime <= expected.
# I: {external, timer, software} vs expected under mask. D: wait data cycles.
I 10 0000 0 000 fff
R 10 4000 0 ffffffffffffffff ffffffffffffffff
R 13 4000 0 ffffffffffffffff ffffffffffffffff
R 11 0000 0 0 ffffffffffffffff
R 12 b000 0 0 ffffffffffffffff
W 10 0000 1 0 ffffffffffffffff
W 11 0000 1 0 ffffffffffffffff
W 11 0000 0 1 ffffffffffffffff
W 12 b000 1 0 ffffffffffffffff
W 10 4000 0123456789abcdef ffffffffffffffff ffffffffffffffff
W 11 4000 7edcba9876543210 ffffffffffffffff ffffffffffffffff
W 12 4000 00f0f0f0f0f0f0f0 ffffffffffffffff ffffffffffffffff
W 13 4000 0 ffffffffffffffff ffffffffffffffff
R 10 4000 0 0123456789abcdef ffffffffffffffff
R 11 4000 0 7edcba9876543210 ffffffffffffffff
R 12 4000 0 00f0f0f0f0f0f0f0 ffffffffffffffff
R 10 0000 0 1 ffffffffffffffff
R 11 0000 0 0 ffffffffffffffff
R 12 b000 0 1 ffffffffffffffff
I 10 0000 0 481 fff
W 11 bff8 1000 0 0
D 10 0000 64 0 0
T 11 bff8 1009 100b 0
W 11 4000 1010 7edcba9876543210 ffffffffffffffff
I 10 0000 0 481 fff
D 10 0000 64 0 0
I 10 0000 0 4a1 fff
W 20 0000 0 0 ffffffffffffffff
W 14 b000 1 0 ffffffffffffffff
W 11 1234 ffff 0 ffffffffffffffff
R 13 0008 0 0 ffffffffffffffff
R 10 0000 0 1 ffffffffffffffff
R 10 b000 0 0 ffffffffffffffff
R 11 4000 0 1010 ffffffffffffffff
W 10 0000 0 1 ffffffffffffffff
W 13 b000 1 0 ffffffffffffffff
I 10 0000 0 ca0 fff

//--- vlog.f
+incdir+common
common/clint_pkg.sv
logic/rtc_strobe.sv
logic/clint_cmd_router.sv
clint/clint_slice.sv
clint/clint_top.sv
tests/tb_clock_gen.sv
tests/tb_clint.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
  -f vlog.f --top-module tb_clint -o tb_clint

./obj_dir/tb_clint | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "Simulation reported errors, see sim.log"
  exit 1
fi
grep -q "Verification passed" sim.log
echo "Simulation clean"
